//--- Bender.yml
package:
  name: ldpc_row

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - ldpc_row_pkg.sv
      - row_config.sv
      - check_msg_store.sv
      - msg_recover.sv
      - min_sum_gen.sv
      - row_unit.sv
      - ldpc_row_top.sv
  - target: simulation
    include_dirs:
      - .
    files:
      - ldpc_row_tb.sv

//--- check_msg_store.sv
`timescale 1ns/1ps
`default_nettype none

`include "ldpc_row_params.svh"

module check_msg_store (
    input  wire logic                   clk,
    input  wire logic                   rst,
    input  wire logic                   clear,
    input  wire logic                   rd_en,
    input  wire ldpc_row_pkg::row_tag_t rd_tag,
    output ldpc_row_pkg::cmsg_t         rd_msg,
    input  wire logic                   wr_en,
    input  wire ldpc_row_pkg::row_tag_t wr_tag,
    input  wire ldpc_row_pkg::cmsg_t    wr_msg
);

    import ldpc_row_pkg::*;

    localparam int ENTRY_W = $clog2(`ROW_ENTRIES);

    cmsg_t mem [`ROW_ENTRIES];
    logic [`ROW_ENTRIES-1:0] valid;
    logic [ENTRY_W-1:0] rd_idx;
    logic [ENTRY_W-1:0] wr_idx;

    function automatic logic [ENTRY_W-1:0] entry_of(row_tag_t t);
        return ENTRY_W'(t.layer * `ROW_DEPTH + t.addr);
    endfunction

    assign rd_idx = entry_of(rd_tag);
    assign wr_idx = entry_of(wr_tag);

    // A write in the same cycle as a clear still marks its entry
    always_ff @(posedge clk)
    begin
        if (!rst)
            valid <= '0;
        else
        begin
            if (clear)
                valid <= '0;
            if (wr_en)
                valid[wr_idx] <= 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (wr_en)
            mem[wr_idx] <= wr_msg;
    end

    // Registered read, empty entries recover as zero
    always_ff @(posedge clk)
    begin
        if (rd_en)
        begin
            if (wr_en && wr_idx == rd_idx)
                rd_msg <= wr_msg;
            else if (valid[rd_idx])
                rd_msg <= mem[rd_idx];
            else
                rd_msg <= '0;
        end
    end

endmodule

`default_nettype wire

//--- ldpc_row.f
+incdir+.
ldpc_row_pkg.sv
row_config.sv
check_msg_store.sv
msg_recover.sv
min_sum_gen.sv
row_unit.sv
ldpc_row_top.sv
ldpc_row_tb.sv

//--- ldpc_row_params.svh
`ifndef LDPC_ROW_PARAMS_SVH
`define LDPC_ROW_PARAMS_SVH

// Row geometry
`define ROW_WC 8
`define ROW_IDX_W 3

// LLR format, two's complement, symmetric range
`define ROW_W 6
`define ROW_MAG_W (`ROW_W - 1)

// Compressed store organisation
`define ROW_LAYERS 2
`define ROW_DEPTH 4
`define ROW_ADDR_W 2
`define ROW_ENTRIES (`ROW_LAYERS * `ROW_DEPTH)

// Input to output, in clock cycles
`define ROW_LATENCY 5

`endif

//--- ldpc_row_pkg.sv
`default_nettype none

`include "ldpc_row_params.svh"

package ldpc_row_pkg;

    // Scalar widths
    typedef logic signed [`ROW_W-1:0] llr_t;
    typedef logic [`ROW_MAG_W-1:0] mag_t;
    typedef logic [`ROW_IDX_W-1:0] idx_t;
    typedef logic [`ROW_ADDR_W-1:0] addr_t;

    // Column 0 sits in the low bits
    typedef logic [`ROW_WC*`ROW_W-1:0] llr_vec_t;
    typedef logic [`ROW_WC-1:0] sign_vec_t;

    typedef struct packed {
        logic layer;
        addr_t addr;
    } row_tag_t;

    typedef struct packed {
        row_tag_t tag;
        llr_vec_t llr;
    } row_req_t;

    // Compressed check-to-variable message of one row
    typedef struct packed {
        mag_t min1;
        mag_t min2;
        idx_t min_idx;
        sign_vec_t sign;
        logic parity;
    } cmsg_t;

    typedef struct packed {
        mag_t offset;
        logic clear;
    } cfg_t;

endpackage

`default_nettype wire

//--- ldpc_row_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "ldpc_row_params.svh"

module ldpc_row_tb;

    import ldpc_row_pkg::*;

    logic clk;
    logic rst;
    logic cfg_wr;
    logic cfg_addr;
    mag_t cfg_wdata;
    logic in_valid;
    row_req_t in_row;
    logic out_valid;
    row_req_t out_row;

    // Stimulus state and the reference store
    logic [15:0] lfsr = 16'd73;
    int cyc = 0;
    string cur_test = "reset";
    mag_t model_offset = '0;
    cmsg_t model_mem [`ROW_ENTRIES];
    logic model_valid [`ROW_ENTRIES];
    int last_edge [`ROW_ENTRIES];
    row_req_t exp_q [$];
    int cyc_q [$];

    ldpc_row_top u_ldpc_row_top (
        .clk       (clk),
        .rst       (rst),
        .cfg_wr    (cfg_wr),
        .cfg_addr  (cfg_addr),
        .cfg_wdata (cfg_wdata),
        .in_valid  (in_valid),
        .in_row    (in_row),
        .out_valid (out_valid),
        .out_row   (out_row)
    );

    always #2 clk = ~clk;

    // Edge counter read on the falling edge only
    always @(posedge clk)
        cyc <= cyc + 1;

    //////////////////////////////
    // Random bits
    //////////////////////////////

    // x^16 + x^14 + x^13 + x^11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int k = 0; k < n; k++)
        begin
            lfsr = lfsr_next(lfsr);
            v = {v[30:0], lfsr[0]};
        end
    endtask

    // -32 lies outside the symmetric LLR range
    task automatic rand_row(output llr_vec_t v);
        logic [31:0] b;
        for (int i = 0; i < `ROW_WC; i++)
        begin
            take_bits(`ROW_W, b);
            if (b[`ROW_W-1:0] == 6'h20)
                b[`ROW_W-1:0] = 6'h21;
            v[i*`ROW_W +: `ROW_W] = b[`ROW_W-1:0];
        end
    endtask

    //////////////////////////////
    // Reference model
    //////////////////////////////

    function automatic int clip_llr(input int v);
        if (v > 31)
            return 31;
        if (v < -31)
            return -31;
        return v;
    endfunction

    function automatic int col_val(input llr_vec_t v, input int i);
        llr_t t;
        t = v[i*`ROW_W +: `ROW_W];
        return t;
    endfunction

    function automatic llr_vec_t expand_msg(input cmsg_t m);
        int mag;
        llr_vec_t r;
        for (int i = 0; i < `ROW_WC; i++)
        begin
            mag = (i == m.min_idx) ? m.min2 : m.min1;
            r[i*`ROW_W +: `ROW_W] = (m.parity ^ m.sign[i]) ? -mag : mag;
        end
        return r;
    endfunction

    function automatic llr_vec_t ref_row(input llr_vec_t l, input cmsg_t old_m,
                                         input mag_t off, output cmsg_t new_m);
        int q [`ROW_WC];
        int mag [`ROW_WC];
        int mn1;
        int mn2;
        int mi;
        llr_vec_t r_old;
        llr_vec_t res;
        r_old = expand_msg(old_m);
        mn1 = 32;
        mn2 = 32;
        mi = 0;
        for (int i = 0; i < `ROW_WC; i++)
        begin
            q[i] = clip_llr(col_val(l, i) - col_val(r_old, i));
            mag[i] = (q[i] < 0) ? -q[i] : q[i];
            if (mag[i] < mn1)
            begin
                mn1 = mag[i];
                mi = i;
            end
        end
        for (int i = 0; i < `ROW_WC; i++)
            if (i != mi && mag[i] < mn2)
                mn2 = mag[i];
        new_m.min1 = mag_t'((mn1 > int'(off)) ? mn1 - int'(off) : 0);
        new_m.min2 = mag_t'((mn2 > int'(off)) ? mn2 - int'(off) : 0);
        new_m.min_idx = idx_t'(mi);
        for (int i = 0; i < `ROW_WC; i++)
            new_m.sign[i] = (q[i] < 0);
        new_m.parity = ^new_m.sign;
        for (int i = 0; i < `ROW_WC; i++)
            res[i*`ROW_W +: `ROW_W] = clip_llr(q[i] + col_val(expand_msg(new_m), i));
        return res;
    endfunction

    //////////////////////////////
    // Checks
    //////////////////////////////

    task automatic end_with_failure();
        $display("Something failed");
        $fatal(1);
    endtask

    task automatic check_row(input llr_vec_t exp, input llr_vec_t act);
        if (act !== exp)
        begin
            $display("Fail %s: row expected %h, actual %h", cur_test, exp, act);
            end_with_failure();
        end
    endtask

    task automatic check_tag(input row_tag_t exp, input row_tag_t act);
        if (act !== exp)
        begin
            $display("Fail %s: tag expected %h, actual %h", cur_test, exp, act);
            end_with_failure();
        end
    endtask

    task automatic expect_latency(input int exp, input int act);
        if (act != exp)
        begin
            $display("Fail %s: output cycle expected %0d, actual %0d", cur_test, exp, act);
            end_with_failure();
        end
    endtask

    always @(negedge clk)
    begin : compare_outputs
        row_req_t exp;
        int exp_cyc;
        if (rst && out_valid)
        begin
            if (exp_q.size() == 0)
            begin
                $display("An output row appeared with none expected in test %s", cur_test);
                end_with_failure();
            end
            else
            begin
                exp = exp_q.pop_front();
                exp_cyc = cyc_q.pop_front();
                check_tag(exp.tag, out_row.tag);
                check_row(exp.llr, out_row.llr);
                expect_latency(exp_cyc, cyc);
            end
        end
    end

    //////////////////////////////
    // Drivers
    //////////////////////////////

    function automatic int entry_index(input row_tag_t t);
        return t.layer * `ROW_DEPTH + t.addr;
    endfunction

    // Holds back a repeated tag until its write-back is due
    task automatic send_row(input row_tag_t tag, input llr_vec_t llr);
        int e;
        int n;
        cmsg_t old_m;
        cmsg_t new_m;
        row_req_t exp;
        e = entry_index(tag);
        n = 0;
        while (cyc + 1 - last_edge[e] < `ROW_LATENCY)
        begin
            if (n == 2 * `ROW_LATENCY)
            begin
                $display("Waiting to resubmit a row tag never ended");
                end_with_failure();
            end
            in_valid = 1'b0;
            @(negedge clk);
            n++;
        end
        old_m = model_valid[e] ? model_mem[e] : '0;
        exp.tag = tag;
        exp.llr = ref_row(llr, old_m, model_offset, new_m);
        model_mem[e] = new_m;
        model_valid[e] = 1'b1;
        last_edge[e] = cyc + 1;
        exp_q.push_back(exp);
        cyc_q.push_back(cyc + 1 + `ROW_LATENCY);
        in_valid = 1'b1;
        in_row.tag = tag;
        in_row.llr = llr;
        @(negedge clk);
        in_valid = 1'b0;
    endtask

    task automatic wait_drain();
        int n;
        n = 0;
        while (exp_q.size() != 0)
        begin
            if (n == 4 * `ROW_LATENCY)
            begin
                $display("Timeout while waiting for the pipeline to drain in %s", cur_test);
                end_with_failure();
            end
            @(negedge clk);
            n++;
        end
        @(negedge clk);
    endtask

    task automatic set_offset(input mag_t v);
        cfg_wr = 1'b1;
        cfg_addr = 1'b0;
        cfg_wdata = v;
        @(negedge clk);
        cfg_wr = 1'b0;
        model_offset = v;
    endtask

    // Valid bits drop one edge after the pulse
    task automatic clear_store();
        cfg_wr = 1'b1;
        cfg_addr = 1'b1;
        cfg_wdata = mag_t'(1);
        @(negedge clk);
        cfg_wr = 1'b0;
        repeat (2) @(negedge clk);
        for (int e = 0; e < `ROW_ENTRIES; e++)
            model_valid[e] = 1'b0;
    endtask

    //////////////////////////////
    // Tests
    //////////////////////////////

    initial
    begin
        logic [31:0] b;
        row_tag_t t;
        llr_vec_t v;
        clk = 1'b0;
        rst = 1'b0;
        cfg_wr = 1'b0;
        cfg_addr = 1'b0;
        cfg_wdata = '0;
        in_valid = 1'b0;
        in_row = '0;
        for (int e = 0; e < `ROW_ENTRIES; e++)
        begin
            model_valid[e] = 1'b0;
            last_edge[e] = -100;
        end
        repeat (10) @(negedge clk);
        rst = 1'b1;
        @(negedge clk);

        // Empty store so Q equals L
        cur_test = "first_pass";
        for (int e = 0; e < `ROW_ENTRIES; e++)
        begin
            rand_row(v);
            t = 3'(e);
            send_row(t, v);
        end
        wait_drain();

        cur_test = "second_pass";
        for (int k = 0; k < 16; k++)
        begin
            take_bits(3, b);
            rand_row(v);
            t = b[2:0];
            send_row(t, v);
        end
        wait_drain();

        cur_test = "offset";
        set_offset(mag_t'(6));
        for (int k = 0; k < 8; k++)
        begin
            take_bits(3, b);
            rand_row(v);
            t = b[2:0];
            send_row(t, v);
        end
        v = {6'sd2, 6'sd6, 6'sd5, -6'sd1, 6'sd2, 6'sd3, -6'sd2, 6'sd1};
        send_row(3'd3, v);
        wait_drain();

        // Stride 3 visits all eight tags
        cur_test = "back_to_back";
        set_offset(mag_t'(2));
        take_bits(3, b);
        for (int k = 0; k < 16; k++)
        begin
            rand_row(v);
            t = 3'(b[2:0] + 3 * k);
            send_row(t, v);
        end
        wait_drain();

        cur_test = "saturation";
        set_offset('0);
        for (int s = 0; s < 2; s++)
        begin
            t = s ? 3'd5 : 3'd0;
            send_row(t, {`ROW_WC{6'h1f}});
            send_row(t, {`ROW_WC{6'h21}});
            send_row(t, {`ROW_WC{6'h1f}});
            take_bits(`ROW_WC, b);
            for (int i = 0; i < `ROW_WC; i++)
                v[i*`ROW_W +: `ROW_W] = b[i] ? 6'h1f : 6'h21;
            send_row(t, v);
        end
        wait_drain();

        cur_test = "store_clear";
        clear_store();
        for (int e = 0; e < `ROW_ENTRIES; e++)
        begin
            rand_row(v);
            t = 3'(e);
            send_row(t, v);
        end
        wait_drain();

        repeat (2 * `ROW_LATENCY) @(negedge clk);
        $display("Everything OK");
        $finish;
    end

endmodule

`default_nettype wire

//--- ldpc_row_top.sv
`timescale 1ns/1ps
`default_nettype none

module ldpc_row_top (
    input  wire logic                   clk,
    input  wire logic                   rst,
    input  wire logic                   cfg_wr,
    input  wire logic                   cfg_addr,
    input  wire ldpc_row_pkg::mag_t     cfg_wdata,
    input  wire logic                   in_valid,
    input  wire ldpc_row_pkg::row_req_t in_row,
    output logic                        out_valid,
    output ldpc_row_pkg::row_req_t      out_row
);

    import ldpc_row_pkg::*;

    // Offset and store clear
    cfg_t cfg;

    row_config u_row_config (
        .clk       (clk),
        .rst       (rst),
        .cfg_wr    (cfg_wr),
        .cfg_addr  (cfg_addr),
        .cfg_wdata (cfg_wdata),
        .cfg       (cfg)
    );

    // Fixed latency row pipeline
    row_unit u_row_unit (
        .clk       (clk),
        .rst       (rst),
        .cfg       (cfg),
        .in_valid  (in_valid),
        .in_row    (in_row),
        .out_valid (out_valid),
        .out_row   (out_row)
    );

endmodule

`default_nettype wire

//--- min_sum_gen.sv
`timescale 1ns/1ps
`default_nettype none

`include "ldpc_row_params.svh"

module min_sum_gen (
    input  wire logic                   clk,
    input  wire logic                   rst,
    input  wire logic                   q_valid,
    input  wire ldpc_row_pkg::llr_vec_t q_vec,
    input  wire ldpc_row_pkg::mag_t     offset,
    output logic                        new_valid,
    output ldpc_row_pkg::cmsg_t         new_msg
);

    import ldpc_row_pkg::*;

    localparam int HALF = `ROW_WC / 2;
    localparam mag_t MAG_MAX = '1;

    mag_t mag_c [`ROW_WC];
    sign_vec_t sign_c;
    mag_t half_min_c [2];
    idx_t half_idx_c [2];

    // Stage A registers
    logic valid_a;
    mag_t mag_a [`ROW_WC];
    sign_vec_t sign_a;
    mag_t half_min_a [2];
    idx_t half_idx_a [2];

    mag_t min1_c;
    mag_t min2_c;
    idx_t idx_c;

    // |Q| limited to the magnitude range, -32 maps to 31
    function automatic mag_t abs_sat(llr_t v);
        logic [`ROW_W-1:0] a;
        a = v[`ROW_W-1] ? -v : v;
        if (a > `ROW_W'(MAG_MAX))
            return MAG_MAX;
        return a[`ROW_MAG_W-1:0];
    endfunction

    function automatic mag_t sub_floor(mag_t m, mag_t off);
        return (m > off) ? m - off : '0;
    endfunction

    //////////////////////////////
    // Stage A
    //////////////////////////////

    always_comb
    begin
        for (int i = 0; i < `ROW_WC; i++)
        begin
            mag_c[i]  = abs_sat(q_vec[i*`ROW_W +: `ROW_W]);
            sign_c[i] = q_vec[(i+1)*`ROW_W-1];
        end
        // Strict compare keeps the lowest index on ties
        for (int h = 0; h < 2; h++)
        begin
            half_min_c[h] = mag_c[h*HALF];
            half_idx_c[h] = idx_t'(h*HALF);
            for (int j = 1; j < HALF; j++)
            begin
                if (mag_c[h*HALF+j] < half_min_c[h])
                begin
                    half_min_c[h] = mag_c[h*HALF+j];
                    half_idx_c[h] = idx_t'(h*HALF+j);
                end
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (!rst)
            valid_a <= 1'b0;
        else
            valid_a <= q_valid;
    end

    always_ff @(posedge clk)
    begin
        mag_a      <= mag_c;
        sign_a     <= sign_c;
        half_min_a <= half_min_c;
        half_idx_a <= half_idx_c;
    end

    //////////////////////////////
    // Stage B
    //////////////////////////////

    always_comb
    begin
        // Low half wins a tie
        if (half_min_a[1] < half_min_a[0])
        begin
            min1_c = half_min_a[1];
            idx_c  = half_idx_a[1];
        end
        else
        begin
            min1_c = half_min_a[0];
            idx_c  = half_idx_a[0];
        end
        min2_c = MAG_MAX;
        for (int i = 0; i < `ROW_WC; i++)
        begin
            if (idx_t'(i) != idx_c && mag_a[i] < min2_c)
                min2_c = mag_a[i];
        end
    end

    always_ff @(posedge clk)
    begin
        if (!rst)
            new_valid <= 1'b0;
        else
            new_valid <= valid_a;
    end

    always_ff @(posedge clk)
    begin
        new_msg.min1    <= sub_floor(min1_c, offset);
        new_msg.min2    <= sub_floor(min2_c, offset);
        new_msg.min_idx <= idx_c;
        new_msg.sign    <= sign_a;
        new_msg.parity  <= ^sign_a;
    end

endmodule

`default_nettype wire

//--- msg_recover.sv
`timescale 1ns/1ps
`default_nettype none

`include "ldpc_row_params.svh"

module msg_recover (
    input  wire ldpc_row_pkg::cmsg_t msg,
    output ldpc_row_pkg::llr_vec_t   r_vec
);

    import ldpc_row_pkg::*;

    //////////////////////////////
    // Expand min1/min2 and signs
    //////////////////////////////

    always_comb
    begin
        mag_t mag;
        logic neg;
        llr_t val;

        r_vec = '0;
        for (int i = 0; i < `ROW_WC; i++)
        begin
            // The minimum position gets the second minimum
            mag = (idx_t'(i) == msg.min_idx) ? msg.min2 : msg.min1;
            // Extrinsic sign is the row parity without this column
            neg = msg.parity ^ msg.sign[i];
            val = llr_t'({1'b0, mag});
            if (neg)
                val = -val;
            r_vec[i*`ROW_W +: `ROW_W] = val;
        end
    end

endmodule

`default_nettype wire

//--- row_config.sv
`timescale 1ns/1ps
`default_nettype none

module row_config (
    input  wire logic               clk,
    input  wire logic               rst,
    input  wire logic               cfg_wr,
    input  wire logic               cfg_addr,
    input  wire ldpc_row_pkg::mag_t cfg_wdata,
    output ldpc_row_pkg::cfg_t      cfg
);

    import ldpc_row_pkg::*;

    mag_t offset_q;
    logic clear_q;

    // Register 0 holds the min-sum offset
    always_ff @(posedge clk)
    begin
        if (!rst)
            offset_q <= '0;
        else if (cfg_wr && !cfg_addr)
            offset_q <= cfg_wdata;
    end

    // Register 1 bit 0 is self-clearing
    // so the store sees a single cycle pulse
    always_ff @(posedge clk)
    begin
        if (!rst)
            clear_q <= 1'b0;
        else
            clear_q <= cfg_wr && cfg_addr && cfg_wdata[0];
    end

    assign cfg.offset = offset_q;
    assign cfg.clear  = clear_q;

endmodule

`default_nettype wire

//--- row_unit.sv
`timescale 1ns/1ps
`default_nettype none

`include "ldpc_row_params.svh"

module row_unit (
    input  wire logic                   clk,
    input  wire logic                   rst,
    input  wire ldpc_row_pkg::cfg_t     cfg,
    input  wire logic                   in_valid,
    input  wire ldpc_row_pkg::row_req_t in_row,
    output logic                        out_valid,
    output ldpc_row_pkg::row_req_t      out_row
);

    import ldpc_row_pkg::*;

    localparam logic signed [`ROW_W:0] LLR_MAX = (1 <<< `ROW_MAG_W) - 1;

    // Valid queue up to the min-sum input, min_sum_gen carries it from there
    logic [2:0] valid_q;
    row_tag_t tag_q [`ROW_LATENCY];

    llr_vec_t l_s0;
    llr_vec_t l_s1;
    cmsg_t rd_msg;
    cmsg_t old_msg_q;
    llr_vec_t r_old;
    llr_vec_t q_c;
    llr_vec_t q_d [3];

    logic new_valid;
    cmsg_t new_msg;
    llr_vec_t r_new;
    llr_vec_t sum_c;

    // Widened sum or difference, clipped to the symmetric range
    function automatic llr_t sat_add(llr_t a, llr_t b, logic sub);
        logic signed [`ROW_W:0] s;
        s = sub ? ({a[`ROW_W-1], a} - {b[`ROW_W-1], b})
                : ({a[`ROW_W-1], a} + {b[`ROW_W-1], b});
        if (s > LLR_MAX)
            return llr_t'(LLR_MAX);
        if (s < -LLR_MAX)
            return llr_t'(-LLR_MAX);
        return llr_t'(s);
    endfunction

    //////////////////////////////
    // Input register and queues
    //////////////////////////////

    always_ff @(posedge clk)
    begin
        if (!rst)
            valid_q <= '0;
        else
            valid_q <= {valid_q[1:0], in_valid};
    end

    always_ff @(posedge clk)
    begin
        tag_q[0] <= in_row.tag;
        for (int s = 1; s < `ROW_LATENCY; s++)
            tag_q[s] <= tag_q[s-1];
        l_s0      <= in_row.llr;
        l_s1      <= l_s0;
        old_msg_q <= rd_msg;
        q_d[0]    <= q_c;
        q_d[1]    <= q_d[0];
        q_d[2]    <= q_d[1];
    end

    // Read issued with the input capture, write back at the queued tag
    check_msg_store u_store (
        .clk    (clk),
        .rst    (rst),
        .clear  (cfg.clear),
        .rd_en  (in_valid),
        .rd_tag (in_row.tag),
        .rd_msg (rd_msg),
        .wr_en  (new_valid),
        .wr_tag (tag_q[`ROW_LATENCY-1]),
        .wr_msg (new_msg)
    );

    //////////////////////////////
    // Q = L - old messages
    //////////////////////////////

    msg_recover u_recover_old (
        .msg   (old_msg_q),
        .r_vec (r_old)
    );

    always_comb
    begin
        for (int i = 0; i < `ROW_WC; i++)
            q_c[i*`ROW_W +: `ROW_W] = sat_add(l_s1[i*`ROW_W +: `ROW_W],
                                              r_old[i*`ROW_W +: `ROW_W], 1'b1);
    end

    min_sum_gen u_min_sum (
        .clk       (clk),
        .rst       (rst),
        .q_valid   (valid_q[2]),
        .q_vec     (q_d[0]),
        .offset    (cfg.offset),
        .new_valid (new_valid),
        .new_msg   (new_msg)
    );

    //////////////////////////////
    // Updated LLR = Q + new messages
    //////////////////////////////

    msg_recover u_recover_new (
        .msg   (new_msg),
        .r_vec (r_new)
    );

    always_comb
    begin
        for (int i = 0; i < `ROW_WC; i++)
            sum_c[i*`ROW_W +: `ROW_W] = sat_add(q_d[2][i*`ROW_W +: `ROW_W],
                                                r_new[i*`ROW_W +: `ROW_W], 1'b0);
    end

    always_ff @(posedge clk)
    begin
        if (!rst)
            out_valid <= 1'b0;
        else
            out_valid <= new_valid;
    end

    always_ff @(posedge clk)
    begin
        out_row.tag <= tag_q[`ROW_LATENCY-1];
        out_row.llr <= sum_c;
    end

endmodule

`default_nettype wire
